// File: fletcherPkg.sv
`default_nettype none

package fletcherPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int AddrWidth = 8;  // 256 words in the buffer.
    localparam int WordWidth = 16; // fletcher-32 works on 16-bit words.

    typedef logic [AddrWidth-1:0] bufAddr_t;
    typedef logic [WordWidth-1:0] word_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // host side bundles
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // one checksum job, sampled with cmdStart.
    typedef struct packed {
        bufAddr_t startAddr;
        logic [AddrWidth:0] wordCount; // 0 to 256.
    } checksumCmd_t;

    // host write port into the shared buffer.
    typedef struct packed {
        logic we;
        bufAddr_t addr;
        word_t data;
    } hostWrite_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // engine control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {
        Idle,   // waiting for a start.
        Fetch,  // requesting addresses.
        Drain,  // all granted, waiting on data.
        Finish  // pulse done, latch result.
    } engineState_t;

endpackage

`default_nettype wire

// File: fletcherAccumulator.sv
`default_nettype none

module fletcherAccumulator
    import fletcherPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        clear,
    input  logic        en,
    input  word_t       din,
    output logic [31:0] sums
);

    word_t sumA;
    word_t sumB;
    word_t nextA;
    word_t nextB;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ones complement helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // add with the carry wrapped back in, keeps the residue mod 65535.
    function automatic word_t addEac(word_t x, word_t y);
        logic [WordWidth:0] s;
        s = {1'b0, x} + {1'b0, y};
        return s[WordWidth-1:0] + WordWidth'(s[WordWidth]);
    endfunction

    // 16'hFFFF and 0 are the same residue; report 0.
    function automatic word_t fold(word_t v);
        return (v == '1) ? '0 : v;
    endfunction

    assign nextA = addEac(sumA, din);
    assign nextB = addEac(sumB, nextA); // b takes the updated a.

    always_ff @(posedge clk) begin
        if (rst) begin
            sumA <= '0;
            sumB <= '0;
        end else if (clear) begin
            sumA <= '0;
            sumB <= '0;
        end else if (en) begin
            sumA <= nextA;
            sumB <= nextB;
        end
    end

    assign sums = {fold(sumB), fold(sumA)}; // sum b high, sum a low.

endmodule

`default_nettype wire

// File: checksumEngine.sv
`default_nettype none

module checksumEngine
    import fletcherPkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         cmdStart,
    input  checksumCmd_t cmd,
    output logic         readReq,
    output bufAddr_t     readAddr,
    input  logic         readGrant,
    input  logic         dataValid,
    input  word_t        rdData,
    output logic         busy,
    output logic         done,
    output logic [31:0]  checksum
);

    engineState_t state;
    bufAddr_t addr;
    logic [AddrWidth:0] reqLeft; // words still to be granted.
    logic [AddrWidth:0] rcvLeft; // words still to come back.
    logic accClear;
    logic [31:0] sums;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read port towards the arbiter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign readReq = (state == Fetch); // held until granted.
    assign readAddr = addr;
    assign busy = (state != Idle);

    // a fresh job starts from zero sums.
    assign accClear = (state == Idle) && cmdStart;

    fletcherAccumulator acc_i (
        .clk   (clk),
        .rst   (rst),
        .clear (accClear),
        .en    (dataValid),
        .din   (rdData),
        .sums  (sums)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= Idle;
            done <= 1'b0;
            addr <= '0;
            reqLeft <= '0;
            rcvLeft <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                Idle: begin
                    if (cmdStart) begin
                        addr <= cmd.startAddr;
                        reqLeft <= cmd.wordCount;
                        rcvLeft <= cmd.wordCount;
                        if (cmd.wordCount == '0) begin
                            state <= Finish; // nothing to read.
                        end else begin
                            state <= Fetch;
                        end
                    end
                end
                Fetch: begin
                    if (readGrant) begin
                        addr <= addr + 1'b1;
                        reqLeft <= reqLeft - 1'b1;
                        if (reqLeft == 1) begin
                            state <= Drain; // last address went out.
                        end
                    end
                    if (dataValid) begin
                        rcvLeft <= rcvLeft - 1'b1;
                    end
                end
                Drain: begin
                    if (dataValid) begin
                        rcvLeft <= rcvLeft - 1'b1;
                        if (rcvLeft == 1) begin
                            state <= Finish;
                        end
                    end
                end
                Finish: begin
                    done <= 1'b1;
                    state <= Idle; // busy drops with done.
                end
                default: begin
                    state <= Idle;
                end
            endcase
        end
    end

    // result register, held until the next job finishes.
    always_ff @(posedge clk) begin
        if (state == Finish) begin
            checksum <= sums;
        end
    end

endmodule

`default_nettype wire

// File: bufferArbiter.sv
`default_nettype none

module bufferArbiter
    import fletcherPkg::*;
#(
    parameter int NumEngines = 3
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [NumEngines-1:0]     readReq,
    input  bufAddr_t [NumEngines-1:0] readAddr,
    output logic [NumEngines-1:0]     readGrant,
    output logic                      rdEn,
    output bufAddr_t                  rdAddr,
    output logic [NumEngines-1:0]     dataValid
);

    localparam int IdxWidth = (NumEngines > 1) ? $clog2(NumEngines) : 1;
    localparam logic [IdxWidth-1:0] LastIdx = IdxWidth'(NumEngines - 1);

    logic [IdxWidth-1:0] ptr;    // highest priority this cycle.
    logic [IdxWidth-1:0] winner;
    logic anyReq;

    assign anyReq = |readReq;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // rotating priority pick
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        int cand;
        logic found;
        found = 1'b0;
        winner = '0;
        readGrant = '0;
        cand = 0;
        for (int k = 0; k < NumEngines; k++) begin
            cand = (int'(ptr) + k) % NumEngines; // walk from the pointer.
            if (!found && readReq[cand]) begin
                found = 1'b1;
                winner = IdxWidth'(cand);
                readGrant[cand] = 1'b1;
            end
        end
    end

    assign rdEn = anyReq;
    assign rdAddr = readAddr[winner];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pointer and return steering
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (anyReq) begin
            ptr <= (winner == LastIdx) ? '0 : winner + 1'b1; // skip past the winner.
        end
    end

    // data comes back one cycle after the grant.
    always_ff @(posedge clk) begin
        if (rst) begin
            dataValid <= '0;
        end else begin
            dataValid <= readGrant;
        end
    end

endmodule

`default_nettype wire

// File: dataBuffer.sv
`default_nettype none

module dataBuffer
    import fletcherPkg::*;
(
    input  logic       clk,
    input  hostWrite_t hostWrite,
    input  logic       rdEn,
    input  bufAddr_t   rdAddr,
    output word_t      rdData
);

    localparam int Depth = 2 ** AddrWidth;

    word_t mem [Depth];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // host write port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (hostWrite.we) begin
            mem[hostWrite.addr] <= hostWrite.data;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // engine read port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // a write to the same address this cycle is not seen yet.
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdData <= mem[rdAddr]; // one cycle latency.
        end
    end

endmodule

`default_nettype wire

// File: checksumTop.sv
`default_nettype none

module checksumTop
    import fletcherPkg::*;
#(
    parameter int NumEngines = 3
) (
    input  logic                          clk,
    input  logic                          rst,
    input  hostWrite_t                    hostWrite,
    input  logic [NumEngines-1:0]         cmdStart,
    input  checksumCmd_t [NumEngines-1:0] cmd,
    output logic [NumEngines-1:0]         busy,
    output logic [NumEngines-1:0]         done,
    output logic [NumEngines-1:0][31:0]   checksum
);

    logic [NumEngines-1:0] readReq;
    bufAddr_t [NumEngines-1:0] readAddr;
    logic [NumEngines-1:0] readGrant;
    logic [NumEngines-1:0] dataValid;
    logic rdEn;
    bufAddr_t rdAddr;
    word_t rdData;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // shared buffer and its arbiter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    dataBuffer buffer_i (
        .clk       (clk),
        .hostWrite (hostWrite),
        .rdEn      (rdEn),
        .rdAddr    (rdAddr),
        .rdData    (rdData)
    );

    bufferArbiter #(
        .NumEngines (NumEngines)
    ) arbiter_i (
        .clk       (clk),
        .rst       (rst),
        .readReq   (readReq),
        .readAddr  (readAddr),
        .readGrant (readGrant),
        .rdEn      (rdEn),
        .rdAddr    (rdAddr),
        .dataValid (dataValid)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checksum engines
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar i = 0; i < NumEngines; i++) begin : genEngine
        checksumEngine engine_i (
            .clk       (clk),
            .rst       (rst),
            .cmdStart  (cmdStart[i]),
            .cmd       (cmd[i]),
            .readReq   (readReq[i]),
            .readAddr  (readAddr[i]),
            .readGrant (readGrant[i]),
            .dataValid (dataValid[i]),
            .rdData    (rdData),          // same word to all, dataValid picks.
            .busy      (busy[i]),
            .done      (done[i]),
            .checksum  (checksum[i])
        );
    end

endmodule

`default_nettype wire

// File: checksum_checker.sv
`default_nettype none

module checksumChecker
    import fletcherPkg::*;
#(
    parameter int NumEngines = 3
) (
    input logic                          clk,
    input logic                          rst,
    input hostWrite_t                    hostWrite,
    input logic [NumEngines-1:0]         cmdStart,
    input checksumCmd_t [NumEngines-1:0] cmd,
    input logic [NumEngines-1:0]         busy,
    input logic [NumEngines-1:0]         done,
    input logic [NumEngines-1:0][31:0]   checksum,
    input logic [NumEngines-1:0]         readGrant
);

    timeunit 1ns;
    timeprecision 100ps;

    word_t shadow [2 ** AddrWidth];          // copy of the buffer contents.
    logic [31:0] expSum [NumEngines];
    logic [AddrWidth:0] expCount [NumEngines];
    int unsigned startCycle [NumEngines];
    logic [NumEngines-1:0] solo;             // job ran with no other engine active.
    int unsigned cycleCnt;
    int errCount = 0;

    // plain fletcher-32 over the shadow copy, sums kept mod 65535.
    function automatic logic [31:0] modelSum(bufAddr_t start, logic [AddrWidth:0] count);
        int unsigned a;
        int unsigned b;
        bufAddr_t ad;
        a = 0;
        b = 0;
        ad = start;
        for (int n = 0; n < int'(count); n++) begin
            a = (a + 32'(shadow[ad])) % 65535;
            b = (b + a) % 65535;
            ad = ad + 1'b1;                  // wraps at the buffer end.
        end
        return {b[15:0], a[15:0]};
    endfunction

    always_ff @(posedge clk) begin
        if (hostWrite.we) begin
            shadow[hostWrite.addr] <= hostWrite.data;
        end
    end

    always_ff @(posedge clk) begin
        logic [NumEngines-1:0] others;
        if (rst) begin
            cycleCnt <= 0;
            solo <= '0;
        end else begin
            cycleCnt <= cycleCnt + 1;
            for (int e = 0; e < NumEngines; e++) begin
                others = (busy | cmdStart) & ~(NumEngines'(1) << e);
                if (cmdStart[e] && !busy[e]) begin
                    expSum[e] <= modelSum(cmd[e].startAddr, cmd[e].wordCount);
                    expCount[e] <= cmd[e].wordCount;
                    startCycle[e] <= cycleCnt;
                    solo[e] <= (others == '0);
                end else if (busy[e] && others != '0) begin
                    solo[e] <= 1'b0;         // contention stretches the latency.
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // assertions
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(readGrant))
        else begin
            errCount++;
            $error("more than one read grant in the same cycle: %b", $sampled(readGrant));
        end

    resetIdle: assert property (@(posedge clk) rst |=> (busy == '0 && done == '0))
        else begin
            errCount++;
            $error("busy or done is high right after reset");
        end

    for (genvar i = 0; i < NumEngines; i++) begin : genCheck
        donePulse: assert property (@(posedge clk) disable iff (rst) done[i] |=> !done[i])
            else begin
                errCount++;
                $error("done[%0d] stayed high for more than one cycle", i);
            end

        // model halves stay below 65535, so this also covers the fold.
        doneValue: assert property (@(posedge clk) disable iff (rst)
            done[i] |-> checksum[i] == expSum[i])
            else begin
                errCount++;
                $error("ERR %0t checksum[%0d] got %h expected %h", $time, i,
                    $sampled(checksum[i]), $sampled(expSum[i]));
            end

        soloLatency: assert property (@(posedge clk) disable iff (rst)
            done[i] && solo[i] && expCount[i] != '0
            |-> cycleCnt == startCycle[i] + 32'(expCount[i]) + 32'd3)
            else begin
                errCount++;
                $error("ERR %0t doneCycle[%0d] got %0d expected %0d", $time, i,
                    $sampled(cycleCnt), startCycle[i] + 32'(expCount[i]) + 32'd3);
            end
    end

endmodule

bind checksumTop checksumChecker #(
    .NumEngines (NumEngines)
) checker_i (
    .clk       (clk),
    .rst       (rst),
    .hostWrite (hostWrite),
    .cmdStart  (cmdStart),
    .cmd       (cmd),
    .busy      (busy),
    .done      (done),
    .checksum  (checksum),
    .readGrant (readGrant)
);

`default_nettype wire

// File: checksumTb.sv
`default_nettype none

module checksumTb
    import fletcherPkg::*;
#(
    parameter int NumEngines = 3
);

    timeunit 1ns;
    timeprecision 100ps;

    logic clk = 1'b0;
    logic rst;
    hostWrite_t hostWrite;
    logic [NumEngines-1:0] cmdStart;
    checksumCmd_t [NumEngines-1:0] cmd;
    logic [NumEngines-1:0] busy;
    logic [NumEngines-1:0] done;
    logic [NumEngines-1:0][31:0] checksum;

    checksumCmd_t [NumEngines-1:0] nextCmd; // staged until the next start.
    logic [31:0] rngState = 32'h58798269;
    int unsigned wordSum = 0;               // sets the watchdog limit.
    int unsigned cycles = 0;
    int otherErrors = 0;

    always #10 clk = ~clk;

    checksumTop #(
        .NumEngines (NumEngines)
    ) dut_i (
        .clk       (clk),
        .rst       (rst),
        .hostWrite (hostWrite),
        .cmdStart  (cmdStart),
        .cmd       (cmd),
        .busy      (busy),
        .done      (done),
        .checksum  (checksum)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] xorshift(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic drawRandom(output logic [31:0] r);
        rngState = xorshift(rngState);
        r = rngState;
    endtask

    // data is base with random bits under mask.
    task automatic fillRange(input bufAddr_t start, input int count, input word_t base,
                             input word_t mask);
        logic [31:0] r;
        bufAddr_t a;
        a = start;
        for (int n = 0; n < count; n++) begin
            drawRandom(r);
            @(posedge clk);
            hostWrite <= '{we: 1'b1, addr: a, data: base | (r[15:0] & mask)};
            a = a + 1'b1;
        end
        @(posedge clk);
        hostWrite.we <= 1'b0;
    endtask

    task automatic stageCmd(input int e, input bufAddr_t start, input int count);
        nextCmd[e] = '{startAddr: start, wordCount: (AddrWidth + 1)'(count)};
        wordSum += count;
    endtask

    task automatic stageRandom(input int e, input int maxCount);
        logic [31:0] r;
        drawRandom(r);
        stageCmd(e, r[7:0], 1 + int'(r[31:16]) % maxCount);
    endtask

    task automatic pulseStart(input logic [NumEngines-1:0] mask);
        @(posedge clk);
        cmd <= nextCmd;
        cmdStart <= mask;
        @(posedge clk);
        cmdStart <= '0;
    endtask

    // done is a one-cycle pulse, so look at every falling edge.
    task automatic waitDone(input logic [NumEngines-1:0] mask, input int bound);
        logic [NumEngines-1:0] seen;
        int n;
        seen = '0;
        n = 0;
        while ((seen & mask) != mask && n < bound) begin
            @(negedge clk);
            seen = seen | done;
            n++;
        end
        if ((seen & mask) != mask) begin
            otherErrors++;
            $display("no done from engines %b within %0d cycles", mask & ~seen, bound);
        end
    endtask

    task automatic printTotals();
        $display("closing: %0d assertion errors, %0d other errors",
            dut_i.checker_i.errCount, otherErrors);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        logic [31:0] r;
        logic [NumEngines-1:0] mask;
        rst = 1'b1;
        hostWrite = '0;
        cmdStart = '0;
        cmd = '0;
        nextCmd = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // single engine, no contention.
        fillRange(8'd0, 256, 16'h0000, 16'hFFFF);
        stageCmd(0, 8'd0, 40);
        pulseStart(NumEngines'(1));
        waitDone(NumEngines'(1), 300);
        stageRandom(1, 64);
        pulseStart(NumEngines'(2));
        waitDone(NumEngines'(2), 300);

        // all engines at once on overlapping ranges.
        stageCmd(0, 8'd16, 48);
        stageCmd(1, 8'd32, 40);
        stageCmd(2, 8'd24, 56);
        pulseStart('1);
        waitDone('1, 800);

        // all ones and words near the top of the range.
        fillRange(8'd64, 64, 16'hFFFF, 16'h0000);
        fillRange(8'd128, 64, 16'hFFF0, 16'h000F);
        stageCmd(2, 8'd64, 64);
        stageCmd(0, 8'd128, 64);
        stageCmd(1, 8'd100, 60);
        pulseStart('1);
        waitDone('1, 800);
        stageCmd(0, 8'd200, 256);           // whole buffer, wrapping at the end.
        pulseStart(NumEngines'(1));
        waitDone(NumEngines'(1), 1200);

        // second start while busy is dropped.
        stageCmd(1, 8'd20, 50);
        pulseStart(NumEngines'(2));
        repeat (5) @(posedge clk);
        stageCmd(1, 8'd90, 7);
        pulseStart(NumEngines'(2));
        waitDone(NumEngines'(2), 300);

        // new contents, plus a zero-length job.
        fillRange(8'd0, 64, 16'h0000, 16'hFFFF);
        stageCmd(0, 8'd0, 40);
        stageCmd(2, 8'd10, 0);
        pulseStart(NumEngines'(5));
        waitDone(NumEngines'(5), 300);

        for (int round = 0; round < 6; round++) begin
            drawRandom(r);
            mask = r[NumEngines-1:0];
            if (mask == '0) begin
                mask = '1;
            end
            for (int e = 0; e < NumEngines; e++) begin
                stageRandom(e, 80);
            end
            pulseStart(mask);
            waitDone(mask, 4 * 80 * NumEngines + 100);
        end

        repeat (5) @(posedge clk);
        printTotals();
        if (dut_i.checker_i.errCount + otherErrors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // watchdog, the limit grows with every staged job.
    initial begin
        while (cycles < 4 * wordSum + 2000) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run was stopped after %0d cycles", cycles);
        printTotals();
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
fletcherPkg.sv
fletcherAccumulator.sv
checksumEngine.sv
bufferArbiter.sv
dataBuffer.sv
checksumTop.sv
checksum_checker.sv
checksumTb.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := checksumTb
FILELIST := files.f
RUNFLAGS := +verilator+error+limit+1000
BUILD    := obj_dir
LOG      := sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) $(RUNFLAGS) | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
